//--- hw/axi4s_adv_tlast.sv
`timescale 1ns/1ps
`default_nettype none

module axi4s_adv_tlast
    import axi4s_pkg::*;
(
    input  logic        axi4s_if_from_tx,
    input  logic        aresetn,

    input  logic        in_valid,
    input  axi4s_beat_t in_beat,
    input  logic        out_ready,
    output logic        in_ready,

    output logic        out_valid,
    output axi4s_beat_t out_beat
);

    // Pending beat (p) is the output register; n holds the beat behind it
    logic        p_valid;
    logic        n_valid;
    axi4s_beat_t p_beat;
    axi4s_beat_t n_beat;

    logic        p_valid_nxt;
    logic        n_valid_nxt;
    axi4s_beat_t p_beat_nxt;
    axi4s_beat_t n_beat_nxt;

    logic        in_fire;
    logic        out_fire;

    // Pending beat may leave once it closes a packet or its successor is in
    assign out_valid = p_valid && (p_beat.tlast || n_valid);
    assign out_beat  = p_beat;
    assign out_fire  = out_valid && out_ready;

    // Room for one more beat unless both entries stay occupied
    assign in_ready = !n_valid || out_fire;
    assign in_fire  = in_valid && in_ready;

    always_comb begin
        p_valid_nxt = p_valid;
        n_valid_nxt = n_valid;
        p_beat_nxt  = p_beat;
        n_beat_nxt  = n_beat;

        // Shift forward when the pending beat goes out
        if (out_fire) begin
            p_valid_nxt = n_valid;
            p_beat_nxt  = n_beat;
            n_valid_nxt = 1'b0;
        end

        // n is always free here, so p is the only merge target
        if (in_fire) begin
            if (is_empty_last(in_beat) && p_valid_nxt && !p_beat_nxt.tlast) begin
                // Fold the empty closing beat into the one before it
                p_beat_nxt.tlast = 1'b1;
            end else if (!p_valid_nxt) begin
                p_valid_nxt = 1'b1;
                p_beat_nxt  = in_beat;
            end else begin
                n_valid_nxt = 1'b1;
                n_beat_nxt  = in_beat;
            end
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            p_valid <= 1'b0;
            n_valid <= 1'b0;
        end else begin
            p_valid <= p_valid_nxt;
            n_valid <= n_valid_nxt;
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        p_beat <= p_beat_nxt;
        n_beat <= n_beat_nxt;
    end

endmodule : axi4s_adv_tlast

`default_nettype wire

//--- hw/axi4s_bypass_mux.sv
`timescale 1ns/1ps
`default_nettype none

module axi4s_bypass_mux
    import axi4s_pkg::*;
(
    input  logic        axi4s_if_from_tx,
    input  logic        aresetn,
    input  logic        bypass,

    // Stream input
    input  logic        in_valid,
    input  axi4s_beat_t in_beat,
    output logic        in_ready,

    // Towards the processing path
    output logic        blk_valid,
    output axi4s_beat_t blk_beat,
    input  logic        blk_ready,

    // Back from the processing path
    input  logic        blk_out_valid,
    input  axi4s_beat_t blk_out_beat,
    output logic        blk_out_ready,

    // Towards the bypass path
    output logic        byp_valid,
    output axi4s_beat_t byp_beat,
    input  logic        byp_ready,

    // Back from the bypass path
    input  logic        byp_out_valid,
    input  axi4s_beat_t byp_out_beat,
    output logic        byp_out_ready,

    // Stream output
    output logic        out_valid,
    output axi4s_beat_t out_beat,
    input  logic        out_ready
);

    logic sop;
    logic mode_q;
    logic in_mode;
    logic in_fire;

    // Fresh bypass value only applies to the first beat of a packet
    assign in_mode = sop ? bypass : mode_q;
    assign in_fire = in_valid && in_ready;

    // Start-of-packet tracking on input transfers
    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            sop <= 1'b1;
        end else if (in_fire) begin
            sop <= in_beat.tlast;
        end
    end

    // Mode latched with the first beat, 0 selects the processing path
    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            mode_q <= 1'b0;
        end else if (in_fire && sop) begin
            mode_q <= bypass;
        end
    end

    // Input steering
    assign blk_valid = in_valid && !in_mode;
    assign byp_valid = in_valid && in_mode;
    assign blk_beat  = in_beat;
    assign byp_beat  = in_beat;
    assign in_ready  = in_mode ? byp_ready : blk_ready;

    // Output merge follows the latched mode
    assign out_valid     = mode_q ? byp_out_valid : blk_out_valid;
    assign out_beat      = mode_q ? byp_out_beat : blk_out_beat;
    assign blk_out_ready = out_ready && !mode_q;
    assign byp_out_ready = out_ready && mode_q;

endmodule : axi4s_bypass_mux

`default_nettype wire

//--- hw/axi4s_bypass_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module axi4s_bypass_pipe
    import axi4s_pkg::*;
#(
    parameter int PIPE_STAGES = 2
) (
    input  logic        axi4s_if_from_tx,
    input  logic        aresetn,

    input  logic        in_valid,
    input  axi4s_beat_t in_beat,
    output logic        in_ready,

    output logic        out_valid,
    output axi4s_beat_t out_beat,
    input  logic        out_ready
);

    // Link k feeds slice k; link PIPE_STAGES is the pipe output
    logic [PIPE_STAGES:0] link_valid;
    logic [PIPE_STAGES:0] link_ready;
    axi4s_beat_t          link_beat [0:PIPE_STAGES];

    assign link_valid[0] = in_valid;
    assign link_beat[0]  = in_beat;
    assign in_ready      = link_ready[0];

    generate
        for (genvar g_stage = 0; g_stage < PIPE_STAGES; g_stage++) begin : g_stage_chain
            axi4s_reg_slice u_reg_slice (
                .axi4s_if_from_tx (axi4s_if_from_tx),
                .aresetn          (aresetn),
                .in_valid         (link_valid[g_stage]),
                .in_beat          (link_beat[g_stage]),
                .in_ready         (link_ready[g_stage]),
                .out_valid        (link_valid[g_stage+1]),
                .out_beat         (link_beat[g_stage+1]),
                .out_ready        (link_ready[g_stage+1])
            );
        end
    endgenerate

    assign out_valid               = link_valid[PIPE_STAGES];
    assign out_beat                = link_beat[PIPE_STAGES];
    assign link_ready[PIPE_STAGES] = out_ready;

endmodule : axi4s_bypass_pipe

`default_nettype wire

//--- hw/axi4s_bypass_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi4s_bypass_top
    import axi4s_pkg::*;
#(
    parameter int PIPE_STAGES = 2
) (
    input  logic        axi4s_if_from_tx,
    input  logic        aresetn,
    input  logic        bypass,

    input  logic        in_valid,
    input  axi4s_beat_t in_beat,
    output logic        in_ready,

    output logic        out_valid,
    output axi4s_beat_t out_beat,
    input  logic        out_ready
);

    // Processing path links
    logic        blk_valid;
    axi4s_beat_t blk_beat;
    logic        blk_ready;
    logic        blk_out_valid;
    axi4s_beat_t blk_out_beat;
    logic        blk_out_ready;

    // Bypass path links
    logic        byp_valid;
    axi4s_beat_t byp_beat;
    logic        byp_ready;
    logic        byp_out_valid;
    axi4s_beat_t byp_out_beat;
    logic        byp_out_ready;

    axi4s_adv_tlast u_adv_tlast (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_valid         (blk_valid),
        .in_beat          (blk_beat),
        .in_ready         (blk_ready),
        .out_valid        (blk_out_valid),
        .out_beat         (blk_out_beat),
        .out_ready        (blk_out_ready)
    );

    axi4s_bypass_pipe #(
        .PIPE_STAGES (PIPE_STAGES)
    ) u_bypass_pipe (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_valid         (byp_valid),
        .in_beat          (byp_beat),
        .in_ready         (byp_ready),
        .out_valid        (byp_out_valid),
        .out_beat         (byp_out_beat),
        .out_ready        (byp_out_ready)
    );

    axi4s_bypass_mux u_bypass_mux (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass           (bypass),
        .in_valid         (in_valid),
        .in_beat          (in_beat),
        .in_ready         (in_ready),
        .blk_valid        (blk_valid),
        .blk_beat         (blk_beat),
        .blk_ready        (blk_ready),
        .blk_out_valid    (blk_out_valid),
        .blk_out_beat     (blk_out_beat),
        .blk_out_ready    (blk_out_ready),
        .byp_valid        (byp_valid),
        .byp_beat         (byp_beat),
        .byp_ready        (byp_ready),
        .byp_out_valid    (byp_out_valid),
        .byp_out_beat     (byp_out_beat),
        .byp_out_ready    (byp_out_ready),
        .out_valid        (out_valid),
        .out_beat         (out_beat),
        .out_ready        (out_ready)
    );

endmodule : axi4s_bypass_top

`default_nettype wire

//--- hw/axi4s_pkg.sv
`default_nettype none

package axi4s_pkg;

    // Beat geometry
    localparam int DATA_BYTE_WID = 8;

    // Sideband widths
    localparam int TID_WID   = 2;
    localparam int TDEST_WID = 2;
    localparam int TUSER_WID = 4;

    // One stream transfer, data and sideband together
    typedef struct packed {
        logic [DATA_BYTE_WID-1:0][7:0] tdata;
        logic [DATA_BYTE_WID-1:0]      tkeep;
        logic                          tlast;
        logic [TID_WID-1:0]            tid;
        logic [TDEST_WID-1:0]          tdest;
        logic [TUSER_WID-1:0]          tuser;
    } axi4s_beat_t;

    // True for a closing beat that carries no bytes
    function automatic logic is_empty_last(input axi4s_beat_t beat);
        return beat.tlast && (beat.tkeep == '0);
    endfunction

endpackage : axi4s_pkg

`default_nettype wire

//--- hw/axi4s_reg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axi4s_reg_slice
    import axi4s_pkg::*;
(
    input  logic        axi4s_if_from_tx,
    input  logic        aresetn,

    // Upstream side
    input  logic        in_valid,
    input  axi4s_beat_t in_beat,
    output logic        in_ready,

    // Downstream side
    output logic        out_valid,
    output axi4s_beat_t out_beat,
    input  logic        out_ready
);

    logic        full;
    axi4s_beat_t beat_q;
    logic        load;

    // Accept when empty, or when the held beat leaves this cycle
    assign in_ready = !full || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    // Payload only moves on a load
    always_ff @(posedge axi4s_if_from_tx) begin
        if (load) begin
            beat_q <= in_beat;
        end
    end

    assign out_valid = full;
    assign out_beat  = beat_q;

endmodule : axi4s_reg_slice

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the stream bypass testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module axi4s_bypass_tb \
    -f sources.f \
    -o sim_axi4s_bypass

sim_out=$(./obj_dir/sim_axi4s_bypass)
echo "$sim_out"

if grep -qx "TEST RESULT: PASS" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- sources.f
hw/axi4s_pkg.sv
hw/axi4s_reg_slice.sv
hw/axi4s_bypass_pipe.sv
hw/axi4s_adv_tlast.sv
hw/axi4s_bypass_mux.sv
hw/axi4s_bypass_top.sv
verif/axi4s_bypass_checker.sv
verif/axi4s_bypass_tb.sv

//--- verif/axi4s_bypass_checker.sv
`timescale 1ns/1ps
`default_nettype none

module axi4s_bypass_checker
    import axi4s_pkg::*;
(
    input  logic        axi4s_if_from_tx,
    input  logic        aresetn,
    input  logic        out_valid,
    input  axi4s_beat_t out_beat,
    input  logic        out_ready
);

    // Output idle in the first cycle out of reset
    idle_after_reset: assert property (
        @(posedge axi4s_if_from_tx) !aresetn |=> !out_valid
    ) else $error("out_valid was high in the cycle after reset");

    // Payload frozen while the sink stalls
    beat_held_in_stall: assert property (
        @(posedge axi4s_if_from_tx) disable iff (!aresetn)
        (out_valid && !out_ready) |=> $stable(out_beat)
    ) else $error("out_beat changed while out_valid was high and out_ready low");

    // A beat on offer stays on offer until taken
    valid_held_in_stall: assert property (
        @(posedge axi4s_if_from_tx) disable iff (!aresetn)
        (out_valid && !out_ready) |=> out_valid
    ) else $error("out_valid dropped before its beat was transferred");

endmodule : axi4s_bypass_checker

bind axi4s_bypass_top axi4s_bypass_checker u_bypass_checker (
    .axi4s_if_from_tx (axi4s_if_from_tx),
    .aresetn          (aresetn),
    .out_valid        (out_valid),
    .out_beat         (out_beat),
    .out_ready        (out_ready)
);

`default_nettype wire

//--- verif/axi4s_bypass_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi4s_bypass_tb
    import axi4s_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 500;

    logic        axi4s_if_from_tx;
    logic        aresetn;
    logic        bypass;
    logic        in_valid;
    axi4s_beat_t in_beat;
    logic        in_ready;
    logic        out_valid;
    axi4s_beat_t out_beat;
    logic        out_ready;

    // One table row per test and one flat list of beats
    string       test_name [$];
    bit          test_bypass [$];
    int          test_stall [$];
    int          test_flip [$];
    int          test_first [$];
    axi4s_beat_t stim [$];

    axi4s_beat_t exp_q [$];
    axi4s_beat_t exp_beat;
    string       cur_name;
    int          stall_pct;
    int          err_count;
    int          pass_count;
    int          fail_count;
    bit          timed_out;

    axi4s_bypass_top #(
        .PIPE_STAGES (2)
    ) u_axi4s_bypass_top (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass           (bypass),
        .in_valid         (in_valid),
        .in_beat          (in_beat),
        .in_ready         (in_ready),
        .out_valid        (out_valid),
        .out_beat         (out_beat),
        .out_ready        (out_ready)
    );

    initial begin
        axi4s_if_from_tx = 1'b0;
        forever #2 axi4s_if_from_tx = ~axi4s_if_from_tx;
    end

    // Sink back-pressure
    always @(posedge axi4s_if_from_tx) begin
        out_ready <= (stall_pct == 0) || (int'($urandom_range(99)) >= stall_pct);
    end

    // Output beats are sampled mid-cycle where everything has settled
    always @(negedge axi4s_if_from_tx) begin
        if (aresetn && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Error: %s delivered a beat that was never expected", cur_name);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                exp_beat = exp_q.pop_front();
                assert (out_beat == exp_beat) else begin
                    $display("Mismatch in %s: expected %h, actual %h",
                             cur_name, exp_beat, out_beat);
                    err_count++;
                end
            end
        end
    end

    function automatic axi4s_beat_t make_beat(input int nbytes, input bit last);
        axi4s_beat_t b;
        b.tdata = {$urandom, $urandom};
        b.tkeep = DATA_BYTE_WID'((1 << nbytes) - 1);
        b.tlast = last;
        b.tid   = TID_WID'($urandom);
        b.tdest = TDEST_WID'($urandom);
        b.tuser = TUSER_WID'($urandom);
        return b;
    endfunction

    task automatic open_test(input string name, input bit bp, input int stall, input int flip);
        test_name.push_back(name);
        test_bypass.push_back(bp);
        test_stall.push_back(stall);
        test_flip.push_back(flip);
        test_first.push_back(stim.size());
    endtask

    // Full beats, then a closing beat with last_bytes bytes (0 gives an empty tlast beat)
    task automatic add_packet(input int n_full, input int last_bytes);
        for (int i = 0; i < n_full; i++) begin
            stim.push_back(make_beat(DATA_BYTE_WID, 1'b0));
        end
        stim.push_back(make_beat(last_bytes, 1'b1));
    endtask

    function automatic int test_end(input int t);
        return (t + 1 < test_first.size()) ? test_first[t + 1] : stim.size();
    endfunction

    // Reference model; mode is taken per packet at its first beat
    task automatic build_expected(input int t);
        axi4s_beat_t b;
        axi4s_beat_t prev;
        bit          bp;
        bit          pkt_bp;
        bit          sop;
        bp     = test_bypass[t];
        pkt_bp = bp;
        sop    = 1'b1;
        for (int i = test_first[t]; i < test_end(t); i++) begin
            b = stim[i];
            if (i - test_first[t] == test_flip[t]) bp = !bp;
            if (sop) pkt_bp = bp;
            if (!pkt_bp && !sop && b.tlast && b.tkeep == '0) begin
                prev = exp_q.pop_back();
                prev.tlast = 1'b1;
                exp_q.push_back(prev);
            end else begin
                exp_q.push_back(b);
            end
            sop = b.tlast;
        end
    endtask

    // Starts and ends just after a rising edge
    task automatic send_beat(input axi4s_beat_t b, input bit flip);
        int waited;
        waited = 0;
        in_valid <= 1'b1;
        in_beat  <= b;
        if (flip) bypass <= !bypass;
        @(negedge axi4s_if_from_tx);
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge axi4s_if_from_tx);
            waited++;
        end
        assert (in_ready) else begin
            $display("Error: %s input beat was never accepted", cur_name);
            err_count++;
            timed_out = 1'b1;
        end
        @(posedge axi4s_if_from_tx);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) pass_count++;
        else fail_count++;
        $display("%-20s %s (%0d errors)", name, (errs == 0) ? "passed" : "failed", errs);
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int waited;
        errs_before = err_count;
        waited      = 0;
        cur_name    = test_name[t];
        stall_pct  <= test_stall[t];
        bypass     <= test_bypass[t];
        build_expected(t);
        for (int i = test_first[t]; i < test_end(t) && !timed_out; i++) begin
            send_beat(stim[i], (i - test_first[t]) == test_flip[t]);
        end
        in_valid <= 1'b0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge axi4s_if_from_tx);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("Error: %s drained only partly, %0d beats never came out",
                     cur_name, exp_q.size());
            err_count++;
            timed_out = 1'b1;
        end
        stall_pct <= 0;
        // Quiet gap so that stray extra beats are caught
        for (int k = 0; k < 6; k++) @(posedge axi4s_if_from_tx);
        report_test(cur_name, err_count - errs_before);
    endtask

    initial begin
        aresetn   = 1'b0;
        bypass    = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b1;
        stall_pct = 0;
        void'($urandom(32'h51f2));

        open_test("full_last_keep", 1'b0, 0, -1);
        add_packet(3, 8);
        add_packet(1, 5);
        add_packet(0, 2);
        open_test("empty_last_fold", 1'b0, 0, -1);
        add_packet(2, 0);
        add_packet(0, 0);
        add_packet(4, 0);
        add_packet(0, 8);
        open_test("bypass_keeps_empty", 1'b1, 0, -1);
        add_packet(2, 0);
        add_packet(0, 0);
        add_packet(1, 3);
        open_test("stall_process", 1'b0, 50, -1);
        add_packet(3, 0);
        add_packet(0, 0);
        add_packet(5, 7);
        add_packet(1, 0);
        open_test("stall_bypass", 1'b1, 50, -1);
        add_packet(3, 0);
        add_packet(0, 0);
        add_packet(5, 7);
        add_packet(1, 0);
        open_test("flip_mid_packet", 1'b0, 0, 1);
        add_packet(3, 0);
        open_test("after_flip", 1'b1, 0, -1);
        add_packet(2, 0);

        repeat (RESET_CYCLES) @(posedge axi4s_if_from_tx);
        aresetn <= 1'b1;

        // Nothing may come out before the first beat goes in
        cur_name = "idle_after_reset";
        for (int k = 0; k < 8; k++) begin
            @(negedge axi4s_if_from_tx);
            assert (!out_valid) else begin
                $display("Error: out_valid rose before any input beat was accepted");
                err_count++;
            end
        end
        @(posedge axi4s_if_from_tx);
        report_test(cur_name, err_count);

        for (int t = 0; t < test_name.size() && !timed_out; t++) begin
            run_test(t);
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : axi4s_bypass_tb

`default_nettype wire
